// File: design/esp_link_pkg.sv
package esp_link_pkg;

  typedef logic [7:0] byte_t;

  // command opcodes
  localparam byte_t op_get_cookie  = 8'd0;
  localparam byte_t op_bram_poke   = 8'd1;
  localparam byte_t op_bram_peek   = 8'd2;
  localparam byte_t op_get_version = 8'd15;
  localparam byte_t op_set_led     = 8'd26;
  localparam byte_t op_get_config  = 8'd27;

  localparam byte_t cookie = 8'hAF;

  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;
  localparam byte_t version = {version_major, version_minor};

  localparam int bram_aw    = 12;
  localparam int bram_depth = 1 << bram_aw;

  // register indices in the register region
  localparam logic [1:0] reg_led    = 2'd0;
  localparam logic [1:0] reg_config = 2'd1;

  localparam logic region_ram = 1'b0;
  localparam logic region_reg = 1'b1;

  typedef struct packed {
    logic               region;
    logic [bram_aw-1:0] offset;
  } ram_view_t;

  typedef struct packed {
    logic       region;
    logic [9:0] unused;
    logic [1:0] index;
  } reg_view_t;

  // one bus address, two decodings selected by the region bit
  typedef union packed {
    ram_view_t as_ram;
    reg_view_t as_reg;
  } wb_addr_t;

  typedef enum logic {
    idle,
    read_params
  } state_t;

endpackage

// File: design/wb_if.sv
`timescale 1ns/10ps

interface wb_if;
  import esp_link_pkg::*;

  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  byte_t    dat_w;
  byte_t    dat_r;
  logic     ack;

  // parser side
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // register and RAM target
  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

// File: design/spi_byte_port.sv
`timescale 1ns/10ps

module spi_byte_port (
  input  logic                clk,
  input  logic                reset,
  input  logic                cs_n,
  input  logic                sck,
  input  logic                mosi,
  input  esp_link_pkg::byte_t tx_byte,
  output logic                miso,
  output esp_link_pkg::byte_t rx_byte,
  output logic                rx_valid
);
  import esp_link_pkg::*;

  logic [2:0] sck_r;  // two sync stages plus one for edge detect
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       selected;
  logic [2:0] bit_cnt;
  byte_t      tx_sr;  // reply shift register

  assign sck_rise = (sck_r[2:1] == 2'b01);
  assign sck_fall = (sck_r[2:1] == 2'b10);
  assign selected = ~cs_r[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_r <= '0;
      cs_r  <= '1;  // start deselected
    end else begin
      sck_r <= {sck_r[1:0], sck};
      cs_r  <= {cs_r[0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_r <= {mosi_r[0], mosi};
    if (selected && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_r[1]};  // msb first
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      tx_sr    <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!selected) begin
        bit_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            rx_valid <= 1'b1;  // byte complete
        end
        // first falling edge of a byte picks up the pending reply
        if (sck_fall)
          tx_sr <= (bit_cnt == 3'd1) ? tx_byte : {tx_sr[6:0], 1'b0};
      end
    end
  end

  assign miso = selected & tx_sr[7];  // held low while deselected

endmodule

// File: design/cmd_parser.sv
`timescale 1ns/10ps

module cmd_parser (
  input  logic                clk,
  input  logic                reset,
  input  esp_link_pkg::byte_t rx_byte,
  input  logic                rx_valid,
  input  logic [3:0]          conf,
  output esp_link_pkg::byte_t tx_byte,
  output logic                spi_error,
  wb_if.master                wb
);
  import esp_link_pkg::*;

  state_t     state;
  byte_t      opcode;
  byte_t      addr_lo;
  byte_t      addr_hi;
  logic [1:0] param_cnt;  // parameter bytes still expected
  logic [1:0] idx;
  byte_t      cur_op;
  wb_addr_t   cmd_adr;

  // opcode of the command being completed by rx_byte
  assign cur_op = (state == idle) ? rx_byte : opcode;

  // bus address for that command, built through the union views
  always_comb begin
    cmd_adr = '0;
    case (cur_op)
      op_bram_poke: begin
        cmd_adr.as_ram.region = region_ram;
        cmd_adr.as_ram.offset = {addr_hi[bram_aw-9:0], addr_lo};  // upper nibble dropped
      end
      op_bram_peek: begin
        cmd_adr.as_ram.region = region_ram;
        cmd_adr.as_ram.offset = {rx_byte[bram_aw-9:0], addr_lo};  // high byte arrives last
      end
      op_get_config: begin
        cmd_adr.as_reg.region = region_reg;
        cmd_adr.as_reg.index  = reg_config;
      end
      default: begin
        cmd_adr.as_reg.region = region_reg;
        cmd_adr.as_reg.index  = reg_led;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      param_cnt <= '0;
      idx       <= '0;
      wb.cyc    <= 1'b0;
      wb.stb    <= 1'b0;
      tx_byte   <= '0;
      spi_error <= 1'b0;
    end else begin
      if (wb.cyc && wb.ack) begin
        wb.cyc <= 1'b0;
        wb.stb <= 1'b0;
        if (!wb.we)
          tx_byte <= wb.dat_r;  // peek or config reply
      end

      if (rx_valid) begin
        case (state)
          idle: begin
            opcode <= rx_byte;
            idx    <= '0;
            case (rx_byte)
              op_get_cookie:  tx_byte <= cookie;
              op_get_version: tx_byte <= version;
              op_get_config: begin
                wb.cyc <= 1'b1;
                wb.stb <= 1'b1;
                wb.we  <= 1'b0;
                wb.adr <= cmd_adr;
              end
              op_bram_poke: begin
                param_cnt <= 2'd3;  // addr lo, addr hi, data
                state     <= read_params;
              end
              op_bram_peek: begin
                param_cnt <= 2'd2;
                state     <= read_params;
              end
              op_set_led: begin
                param_cnt <= 2'd1;
                state     <= read_params;
              end
              default: spi_error <= 1'b1;  // sticky until reset
            endcase
          end
          read_params: begin
            idx       <= idx + 2'd1;
            param_cnt <= param_cnt - 2'd1;
            if (idx == 2'd0)
              addr_lo <= rx_byte;
            if (idx == 2'd1)
              addr_hi <= rx_byte;
            if (param_cnt == 2'd1) begin
              // last parameter, launch the bus cycle
              state    <= idle;
              wb.cyc   <= 1'b1;
              wb.stb   <= 1'b1;
              wb.we    <= (opcode != op_bram_peek);
              wb.adr   <= cmd_adr;
              wb.dat_w <= rx_byte;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

endmodule

// File: design/host_regs.sv
`timescale 1ns/10ps

module host_regs (
  input  logic       clk,
  input  logic       reset,
  input  logic [3:0] conf,
  wb_if.slave        wb,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue
);
  import esp_link_pkg::*;

  byte_t      mem [bram_depth];
  byte_t      ram_q;
  byte_t      reg_q;
  logic [2:0] led;
  logic       ram_pend;  // RAM read cycle in its first phase
  logic       is_reg;
  logic       start;

  assign is_reg = (wb.adr.as_reg.region == region_reg);

  // first cycle of a new request
  assign start = wb.cyc & wb.stb & ~wb.ack & ~ram_pend;

  always_ff @(posedge clk) begin
    if (start && !is_reg && wb.we)
      mem[wb.adr.as_ram.offset] <= wb.dat_w;
    ram_q <= mem[wb.adr.as_ram.offset];  // synchronous read
  end

  // registers ack after one cycle, RAM after two
  always_ff @(posedge clk) begin
    if (reset) begin
      wb.ack   <= 1'b0;
      ram_pend <= 1'b0;
    end else begin
      wb.ack   <= (start & is_reg) | ram_pend;
      ram_pend <= start & ~is_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      led <= '0;
    else if (start && is_reg && wb.we && wb.adr.as_reg.index == reg_led)
      led <= wb.dat_w[2:0];
  end

  always_comb begin
    case (wb.adr.as_reg.index)
      reg_led:    reg_q = {5'b00000, led};
      reg_config: reg_q = {4'b0000, ~conf};  // switches are active low
      default:    reg_q = '0;
    endcase
  end

  assign wb.dat_r = is_reg ? reg_q : ram_q;

  assign led_red   = led[0];
  assign led_green = led[1];
  assign led_blue  = led[2];

endmodule

// File: design/esp_link_top.sv
`timescale 1ns/10ps

module esp_link_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       cs_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  input  logic [3:0] conf,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       spi_error
);
  import esp_link_pkg::*;

  byte_t rx_byte;
  byte_t tx_byte;
  logic  rx_valid;

  wb_if wb ();

  spi_byte_port u_spi (
    .clk      (clk),
    .reset    (reset),
    .cs_n     (cs_n),
    .sck      (sck),
    .mosi     (mosi),
    .tx_byte  (tx_byte),
    .miso     (miso),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  cmd_parser u_parser (
    .clk       (clk),
    .reset     (reset),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .conf      (conf),
    .tx_byte   (tx_byte),
    .spi_error (spi_error),
    .wb        (wb.master)
  );

  host_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .conf      (conf),
    .wb        (wb.slave),
    .led_red   (led_red),
    .led_green (led_green),
    .led_blue  (led_blue)
  );

endmodule

// File: test/esp_link_asserts.sv
`timescale 1ns/10ps

module esp_link_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   cyc,
  input logic                   stb,
  input logic                   ack,
  input esp_link_pkg::wb_addr_t adr
);

  int error_count = 0;  // summed by the testbench at the end

  ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
    else begin
      $error("ack seen outside an active bus cycle");
      error_count++;
    end

  stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
    else begin
      $error("stb high while cyc is low");
      error_count++;
    end

  // request must wait for ack with the address held
  stb_held: assert property (@(posedge clk) disable iff (reset)
    (stb && !ack) |=> (stb && $stable(adr)))
    else begin
      $error("stb dropped or adr changed before ack");
      error_count++;
    end

  ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else begin
      $error("ack held for two cycles");
      error_count++;
    end

endmodule

// File: test/esp_link_tb.sv
`timescale 1ns/10ps

module esp_link_tb;
  import esp_link_pkg::*;

  localparam int n_pokes      = 40;
  localparam int byte_clks    = 8 * 12 + 20;  // eight bits plus the gap
  localparam int total_bytes  = 4 + n_pokes * 8 + 8 * 2 + 8 * 2 + 9 + 2;
  localparam int timeout_clks = 2 * total_bytes * byte_clks;

  logic       clk;
  logic       reset;
  logic       cs_n;
  logic       sck;
  logic       mosi;
  logic       miso;
  logic [3:0] conf;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       spi_error;

  byte_t       ram_model [int];  // keyed on the 12-bit offset
  logic [2:0]  led_model;
  logic        err_model;
  logic [15:0] poked [$];
  int          pass_count;
  int          fail_count;
  int          test_fails;

  esp_link_top dut (
    .clk       (clk),
    .reset     (reset),
    .cs_n      (cs_n),
    .sck       (sck),
    .mosi      (mosi),
    .miso      (miso),
    .conf      (conf),
    .led_red   (led_red),
    .led_green (led_green),
    .led_blue  (led_blue),
    .spi_error (spi_error)
  );

  bind host_regs esp_link_asserts u_asserts (
    .clk   (clk),
    .reset (reset),
    .cyc   (wb.cyc),
    .stb   (wb.stb),
    .ack   (wb.ack),
    .adr   (wb.adr)
  );

  always #50 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic compare(input string name, input byte_t expected, input byte_t actual);
    assert (actual == expected) begin
      pass_count++;
    end else begin
      $display("FAIL %s expected %h got %h", name, expected, actual);
      fail_count++;
      test_fails++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_fails == 0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d checks failed", name, test_fails);
    test_fails = 0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) next_cycle();
    reset = 1'b0;
    led_model = '0;
    err_model = 1'b0;
  endtask

  // mode 0 byte with the reply one bit behind mosi
  task automatic transfer_byte(input byte_t tx, output byte_t rx);
    rx = '0;
    repeat (20) next_cycle();
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (6) next_cycle();
      if (i < 7)
        rx[i + 1] = miso;
      sck = 1'b1;
      repeat (6) next_cycle();
      sck = 1'b0;
    end
    repeat (6) next_cycle();
    rx[0] = miso;  // lsb only shows after the last fall
  endtask

  task automatic open_frame();
    cs_n = 1'b0;
  endtask

  task automatic close_frame();
    mosi = 1'b0;
    cs_n = 1'b1;
    repeat (4) next_cycle();
  endtask

  task automatic query(input byte_t op, output byte_t reply);
    byte_t unused;
    open_frame();
    transfer_byte(op, unused);
    transfer_byte(8'h00, reply);  // filler clocks the reply out
    close_frame();
  endtask

  task automatic poke(input logic [15:0] addr, input byte_t data);
    byte_t unused;
    open_frame();
    transfer_byte(8'd1, unused);
    transfer_byte(addr[7:0], unused);
    transfer_byte(addr[15:8], unused);
    transfer_byte(data, unused);
    close_frame();
    ram_model[int'(addr[11:0])] = data;  // upper nibble ignored
  endtask

  task automatic peek(input logic [15:0] addr, output byte_t reply);
    byte_t unused;
    open_frame();
    transfer_byte(8'd2, unused);
    transfer_byte(addr[7:0], unused);
    transfer_byte(addr[15:8], unused);
    transfer_byte(8'h00, reply);
    close_frame();
  endtask

  task automatic write_led(input byte_t data);
    byte_t unused;
    open_frame();
    transfer_byte(8'd26, unused);
    transfer_byte(data, unused);
    close_frame();
    led_model = data[2:0];
  endtask

  task automatic check_outputs();
    compare("led_red", {7'd0, led_model[0]}, {7'd0, led_red});
    compare("led_green", {7'd0, led_model[1]}, {7'd0, led_green});
    compare("led_blue", {7'd0, led_model[2]}, {7'd0, led_blue});
    compare("spi_error", {7'd0, err_model}, {7'd0, spi_error});
  endtask

  function automatic bit is_kept_op(input byte_t op);
    return op inside {8'd0, 8'd1, 8'd2, 8'd15, 8'd26, 8'd27};
  endfunction

  initial begin
    byte_t       reply;
    byte_t       data;
    byte_t       op;
    logic [15:0] addr;
    logic [15:0] tmp;
    logic [3:0]  cfg;
    int          j;
    clk        = 1'b0;
    reset      = 1'b1;
    cs_n       = 1'b1;
    sck        = 1'b0;
    mosi       = 1'b0;
    conf       = 4'h0;
    pass_count = 0;
    fail_count = 0;
    test_fails = 0;
    void'($urandom(32'h92be));
    apply_reset();

    query(8'd0, reply);
    compare("miso cookie", 8'hAF, reply);
    query(8'd15, reply);
    compare("miso version", {3'd0, 5'd3}, reply);
    end_test("cookie_version");

    for (int i = 0; i < n_pokes; i++) begin
      addr = 16'($urandom);
      data = 8'($urandom);
      poke(addr, data);
      poked.push_back(addr);
    end
    for (int i = n_pokes - 1; i > 0; i--) begin
      j = $urandom % (i + 1);
      tmp = poked[i];
      poked[i] = poked[j];
      poked[j] = tmp;
    end
    foreach (poked[i]) begin
      addr = {4'($urandom), poked[i][11:0]};  // fresh upper bits
      peek(addr, reply);
      compare("miso peek", ram_model[int'(addr[11:0])], reply);
    end
    end_test("ram_poke_peek");

    repeat (8) begin
      write_led(8'($urandom));
      check_outputs();
    end
    end_test("set_led");

    repeat (8) begin
      cfg = 4'($urandom);
      conf = cfg;
      query(8'd27, reply);
      compare("miso config", {4'h0, ~cfg}, reply);
    end
    end_test("get_config");

    compare("spi_error", 8'h00, {7'd0, spi_error});
    op = 8'($urandom);
    while (is_kept_op(op))
      op = 8'($urandom);
    open_frame();
    transfer_byte(op, reply);
    close_frame();
    err_model = 1'b1;
    check_outputs();
    query(8'd0, reply);
    compare("miso cookie", 8'hAF, reply);
    addr = {4'($urandom), poked[0][11:0]};
    peek(addr, reply);
    compare("miso peek", ram_model[int'(addr[11:0])], reply);
    write_led(8'($urandom));
    check_outputs();  // error flag must still be set
    end_test("unknown_opcode");

    write_led(8'h07);
    check_outputs();
    apply_reset();
    check_outputs();
    end_test("second_reset");

    assert (dut.u_regs.u_asserts.error_count == 0) else begin
      $display("bus protocol assertions failed %0d times", dut.u_regs.u_asserts.error_count);
      fail_count++;
    end
    $display("checks passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // twice the byte count times the byte time
  initial begin
    repeat (timeout_clks) @(posedge clk);
    $display("timeout after %0d clock cycles, the tests did not complete", timeout_clks);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: list.f
design/esp_link_pkg.sv
design/wb_if.sv
design/spi_byte_port.sv
design/cmd_parser.sv
design/host_regs.sv
design/esp_link_top.sv
test/esp_link_asserts.sv
test/esp_link_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = esp_link_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
